/* hw/bcjr_defs.svh */
`ifndef BCJR_DEFS_SVH
`define BCJR_DEFS_SVH

// Symbol, alpha, gamma, LLR and extrinsic width
`define BCJR_METRIC_W 16

// Beta accumulator width, extra bits for headroom
`define BCJR_BETA_W 21

// Trellis states
`define BCJR_NSTATES 8

// Symbol index and memory address width
`define BCJR_ADDR_W 13

// Symbol memory depth, longest block
`define BCJR_MAX_BLKLEN 6144

// Start value of states 1 to 7, state 0 starts at 0
`define BCJR_BETA_INIT (-128)

`endif

/* hw/bcjr_pkg.sv */
`default_nettype none

`include "bcjr_defs.svh"

package bcjr_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [`BCJR_METRIC_W-1:0] metric_t;

	// Unnormalised beta
	typedef logic signed [`BCJR_BETA_W-1:0] beta_t;

	typedef logic [`BCJR_ADDR_W-1:0] idx_t;

	////////////////////////////////////////////////////////////////////////////
	// Per-state vectors
	////////////////////////////////////////////////////////////////////////////

	// Element s belongs to trellis state s
	typedef metric_t [`BCJR_NSTATES-1:0] alpha_vec_t;

	typedef metric_t [`BCJR_NSTATES-1:0] cand_vec_t;

endpackage

`default_nettype wire

/* hw/bcjr_if.sv */
`default_nettype none

// Symbol read back from the store, highest index first
interface branch_if;
	logic valid;
	logic first;
	bcjr_pkg::idx_t idx;
	bcjr_pkg::metric_t gamma1;
	bcjr_pkg::metric_t gamma2;
	bcjr_pkg::alpha_vec_t alpha;
	bcjr_pkg::metric_t sys;
	bcjr_pkg::metric_t apriori;

	modport source (output valid, first, idx, gamma1, gamma2, alpha, sys, apriori);
	modport sink (input valid, first, idx, gamma1, gamma2, alpha, sys, apriori);
endinterface

// Candidate sums for bit 1 and bit 0
interface cand_if;
	logic valid;
	bcjr_pkg::idx_t idx;
	bcjr_pkg::cand_vec_t cand1;
	bcjr_pkg::cand_vec_t cand2;
	bcjr_pkg::metric_t sys;
	bcjr_pkg::metric_t apriori;

	modport source (output valid, idx, cand1, cand2, sys, apriori);
	modport sink (input valid, idx, cand1, cand2, sys, apriori);
endinterface

interface llr_if;
	logic valid;
	bcjr_pkg::idx_t idx;
	bcjr_pkg::metric_t llr;
	bcjr_pkg::metric_t sys;
	bcjr_pkg::metric_t apriori;

	modport source (output valid, idx, llr, sys, apriori);
	modport sink (input valid, idx, llr, sys, apriori);
endinterface

`default_nettype wire

/* hw/sym_store.sv */
`default_nettype none

`include "bcjr_defs.svh"

module sym_store (
	input wire logic clk,
	input wire logic rst,
	input wire logic blk_valid_i,
	input wire bcjr_pkg::idx_t blklen_i,
	input wire logic sym_valid_i,
	input wire bcjr_pkg::metric_t sys_i,
	input wire bcjr_pkg::metric_t apriori_i,
	input wire bcjr_pkg::metric_t gamma1_i,
	input wire bcjr_pkg::metric_t gamma2_i,
	input wire bcjr_pkg::alpha_vec_t alpha_i,
	output logic busy_o,
	branch_if.source branch
);

	localparam int WORD_W = (4 + `BCJR_NSTATES) * `BCJR_METRIC_W;
	// Cycles from the last read until its result leaves the pipeline
	localparam int DRAIN_CYCLES = 6;

	typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_RUN, ST_DRAIN} state_t;

	state_t state;
	bcjr_pkg::idx_t blklen_q;
	bcjr_pkg::idx_t last_idx;
	bcjr_pkg::idx_t addr;
	logic [2:0] drain_cnt;
	logic wr_en;
	logic rd_en;
	logic [WORD_W-1:0] wr_word;
	logic [WORD_W-1:0] rd_word;
	logic [WORD_W-1:0] mem [0:`BCJR_MAX_BLKLEN-1];

	assign last_idx = blklen_q - 1'b1;
	assign wr_en = (state == ST_LOAD) && sym_valid_i;
	assign rd_en = (state == ST_RUN);
	assign wr_word = {sys_i, apriori_i, gamma1_i, gamma2_i, alpha_i};
	assign busy_o = (state != ST_IDLE);

	// Address counts up while loading, down while running
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			blklen_q <= '0;
			addr <= '0;
			drain_cnt <= '0;
		end else begin
			case (state)
			ST_IDLE: begin
				if (blk_valid_i) begin
					blklen_q <= blklen_i;
					addr <= '0;
					state <= ST_LOAD;
				end
			end
			ST_LOAD: begin
				// Last write leaves addr on the top index
				if (sym_valid_i) begin
					if (addr == last_idx)
						state <= ST_RUN;
					else
						addr <= addr + 1'b1;
				end
			end
			ST_RUN: begin
				if (addr == '0) begin
					drain_cnt <= 3'(DRAIN_CYCLES - 1);
					state <= ST_DRAIN;
				end else begin
					addr <= addr - 1'b1;
				end
			end
			ST_DRAIN: begin
				if (drain_cnt == '0)
					state <= ST_IDLE;
				else
					drain_cnt <= drain_cnt - 1'b1;
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[addr] <= wr_word;
		if (rd_en)
			rd_word <= mem[addr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			branch.valid <= 1'b0;
			branch.first <= 1'b0;
		end else begin
			branch.valid <= rd_en;
			branch.first <= rd_en && (addr == last_idx);
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en)
			branch.idx <= addr;
	end

	assign {branch.sys, branch.apriori, branch.gamma1, branch.gamma2, branch.alpha} = rd_word;

endmodule

`default_nettype wire

/* hw/beta_recursion.sv */
`default_nettype none

`include "bcjr_defs.svh"

module beta_recursion (
	input wire logic clk,
	input wire logic rst,
	branch_if.sink branch,
	cand_if.source cand
);

	// Beta partner of each state in the bit-1 and bit-0 candidate
	localparam int P1 [`BCJR_NSTATES] = '{4, 0, 1, 5, 6, 2, 3, 7};
	localparam int P2 [`BCJR_NSTATES] = '{0, 4, 5, 1, 2, 6, 7, 3};
	// States 2 to 5 take gamma2
	localparam logic [`BCJR_NSTATES-1:0] USE_G2 = 8'b0011_1100;

	bcjr_pkg::beta_t beta_q [`BCJR_NSTATES];
	bcjr_pkg::beta_t b_cur [`BCJR_NSTATES];
	bcjr_pkg::beta_t beta_nxt [`BCJR_NSTATES];
	bcjr_pkg::metric_t nb [`BCJR_NSTATES];
	bcjr_pkg::beta_t g1;
	bcjr_pkg::beta_t g2;
	bcjr_pkg::cand_vec_t cand1_c;
	bcjr_pkg::cand_vec_t cand2_c;

	function automatic bcjr_pkg::beta_t bmax(input bcjr_pkg::beta_t a,
		input bcjr_pkg::beta_t b);
		return (a > b) ? a : b;
	endfunction

	assign g1 = bcjr_pkg::beta_t'(branch.gamma1);
	assign g2 = bcjr_pkg::beta_t'(branch.gamma2);

	// beta(k+1), or the termination values on the top index
	always_comb begin
		for (int s = 0; s < `BCJR_NSTATES; s++) begin
			if (!branch.first)
				b_cur[s] = beta_q[s];
			else if (s == 0)
				b_cur[s] = '0;
			else
				b_cur[s] = bcjr_pkg::beta_t'(`BCJR_BETA_INIT);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Butterflies
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		beta_nxt[0] = bmax(b_cur[0] + g1, b_cur[4] - g1);
		beta_nxt[1] = bmax(b_cur[4] + g1, b_cur[0] - g1);
		beta_nxt[2] = bmax(b_cur[5] + g2, b_cur[1] - g2);
		beta_nxt[3] = bmax(b_cur[1] + g2, b_cur[5] - g2);
		beta_nxt[4] = bmax(b_cur[2] + g2, b_cur[6] - g2);
		beta_nxt[5] = bmax(b_cur[6] + g2, b_cur[2] - g2);
		beta_nxt[6] = bmax(b_cur[7] + g1, b_cur[3] - g1);
		beta_nxt[7] = bmax(b_cur[3] + g1, b_cur[7] - g1);
	end

	////////////////////////////////////////////////////////////////////////////
	// LLR candidates
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		bcjr_pkg::metric_t gs;
		for (int s = 0; s < `BCJR_NSTATES; s++) begin
			// Relative to state 0, then cut to metric width
			nb[s] = bcjr_pkg::metric_t'(b_cur[s] - b_cur[0]);
		end
		for (int s = 0; s < `BCJR_NSTATES; s++) begin
			gs = USE_G2[s] ? branch.gamma2 : branch.gamma1;
			cand1_c[s] = branch.alpha[s] - gs + nb[P1[s]];
			cand2_c[s] = branch.alpha[s] + gs + nb[P2[s]];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			cand.valid <= 1'b0;
		else
			cand.valid <= branch.valid;
	end

	always_ff @(posedge clk) begin
		if (branch.valid) begin
			beta_q <= beta_nxt;
			cand.idx <= branch.idx;
			cand.cand1 <= cand1_c;
			cand.cand2 <= cand2_c;
			cand.sys <= branch.sys;
			cand.apriori <= branch.apriori;
		end
	end

endmodule

`default_nettype wire

/* hw/llr_max_tree.sv */
`default_nettype none

module llr_max_tree (
	input wire logic clk,
	input wire logic rst,
	cand_if.sink cand,
	llr_if.source llr
);

	bcjr_pkg::metric_t m1_q [4];
	bcjr_pkg::metric_t m2_q [4];
	bcjr_pkg::metric_t top1;
	bcjr_pkg::metric_t top2;
	bcjr_pkg::idx_t idx_q;
	bcjr_pkg::metric_t sys_q;
	bcjr_pkg::metric_t apriori_q;
	logic valid_q;

	function automatic bcjr_pkg::metric_t mmax(input bcjr_pkg::metric_t a,
		input bcjr_pkg::metric_t b);
		return (a > b) ? a : b;
	endfunction

	assign top1 = mmax(mmax(m1_q[0], m1_q[1]), mmax(m1_q[2], m1_q[3]));
	assign top2 = mmax(mmax(m2_q[0], m2_q[1]), mmax(m2_q[2], m2_q[3]));

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			llr.valid <= 1'b0;
		end else begin
			valid_q <= cand.valid;
			llr.valid <= valid_q;
		end
	end

	// Pairwise maxima, then the final reduction
	always_ff @(posedge clk) begin
		if (cand.valid) begin
			for (int i = 0; i < 4; i++) begin
				m1_q[i] <= mmax(cand.cand1[2*i], cand.cand1[2*i+1]);
				m2_q[i] <= mmax(cand.cand2[2*i], cand.cand2[2*i+1]);
			end
			idx_q <= cand.idx;
			sys_q <= cand.sys;
			apriori_q <= cand.apriori;
		end
		if (valid_q) begin
			llr.llr <= top1 - top2;
			llr.idx <= idx_q;
			llr.sys <= sys_q;
			llr.apriori <= apriori_q;
		end
	end

endmodule

`default_nettype wire

/* hw/extrinsic_scale.sv */
`default_nettype none

`include "bcjr_defs.svh"

module extrinsic_scale (
	input wire logic clk,
	input wire logic rst,
	llr_if.sink llr,
	output logic out_valid_o,
	output bcjr_pkg::idx_t idx_o,
	output bcjr_pkg::metric_t llr_o,
	output bcjr_pkg::metric_t ext_o
);

	bcjr_pkg::metric_t d_q;
	bcjr_pkg::metric_t llr_q;
	bcjr_pkg::idx_t idx_q;
	logic valid_q;
	logic [`BCJR_METRIC_W-1:0] mag;
	logic [`BCJR_METRIC_W-1:0] quo;
	logic [`BCJR_METRIC_W-1:0] rnd;

	// Three quarters of d, quarter rounded up only for remainder 3
	assign mag = d_q[`BCJR_METRIC_W-1] ? -d_q : d_q;
	assign quo = mag >> 2;
	assign rnd = (mag[1:0] == 2'b11) ? quo + 1'b1 : quo;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			out_valid_o <= 1'b0;
		end else begin
			valid_q <= llr.valid;
			out_valid_o <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (llr.valid) begin
			d_q <= llr.llr - llr.sys - llr.apriori;
			llr_q <= llr.llr;
			idx_q <= llr.idx;
		end
		if (valid_q) begin
			ext_o <= d_q[`BCJR_METRIC_W-1] ? d_q + rnd : d_q - rnd;
			llr_o <= llr_q;
			idx_o <= idx_q;
		end
	end

endmodule

`default_nettype wire

/* hw/beta_llr_top.sv */
`default_nettype none

module beta_llr_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic blk_valid_i,
	input wire bcjr_pkg::idx_t blklen_i,
	input wire logic sym_valid_i,
	input wire bcjr_pkg::metric_t sys_i,
	input wire bcjr_pkg::metric_t apriori_i,
	input wire bcjr_pkg::metric_t gamma1_i,
	input wire bcjr_pkg::metric_t gamma2_i,
	input wire bcjr_pkg::alpha_vec_t alpha_i,
	output logic out_valid_o,
	output bcjr_pkg::idx_t idx_o,
	output bcjr_pkg::metric_t llr_o,
	output bcjr_pkg::metric_t ext_o,
	output logic busy_o
);

	branch_if i_branch_if ();
	cand_if i_cand_if ();
	llr_if i_llr_if ();

	// Store, then beta step, max tree and scaling at fixed latency
	sym_store i_sym_store (
		.clk(clk),
		.rst(rst),
		.blk_valid_i(blk_valid_i),
		.blklen_i(blklen_i),
		.sym_valid_i(sym_valid_i),
		.sys_i(sys_i),
		.apriori_i(apriori_i),
		.gamma1_i(gamma1_i),
		.gamma2_i(gamma2_i),
		.alpha_i(alpha_i),
		.busy_o(busy_o),
		.branch(i_branch_if.source)
	);

	beta_recursion i_beta_recursion (
		.clk(clk),
		.rst(rst),
		.branch(i_branch_if.sink),
		.cand(i_cand_if.source)
	);

	llr_max_tree i_llr_max_tree (
		.clk(clk),
		.rst(rst),
		.cand(i_cand_if.sink),
		.llr(i_llr_if.source)
	);

	extrinsic_scale i_extrinsic_scale (
		.clk(clk),
		.rst(rst),
		.llr(i_llr_if.sink),
		.out_valid_o(out_valid_o),
		.idx_o(idx_o),
		.llr_o(llr_o),
		.ext_o(ext_o)
	);

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`default_nettype none

// Free running clock, period 4
module tb_clk_gen (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #2 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb/beta_llr_sva.sv */
`default_nettype none

module beta_llr_sva (
	input wire logic clk,
	input wire logic rst,
	input wire logic out_valid_o,
	input wire logic busy_o,
	input wire bcjr_pkg::idx_t idx_o
);

	a_no_valid_in_reset: assert property (@(posedge clk) rst |-> !out_valid_o)
		else $error("out_valid_o high during reset");

	// Results stream out in descending index order
	a_idx_descending: assert property (@(posedge clk) disable iff (rst)
		out_valid_o && $past(out_valid_o) |-> idx_o == $past(idx_o) - 1'b1)
		else $error("idx_o did not decrease by one");

	a_valid_while_busy: assert property (@(posedge clk) disable iff (rst)
		out_valid_o |-> busy_o)
		else $error("out_valid_o high while busy_o low");

endmodule

bind beta_llr_top beta_llr_sva i_beta_llr_sva (
	.clk(clk),
	.rst(rst),
	.out_valid_o(out_valid_o),
	.busy_o(busy_o),
	.idx_o(idx_o)
);

`default_nettype wire

/* tb/beta_llr_tb.sv */
`default_nettype none

module beta_llr_tb;

	logic clk;
	logic rst;
	logic blk_valid_i;
	bcjr_pkg::idx_t blklen_i;
	logic sym_valid_i;
	bcjr_pkg::metric_t sys_i;
	bcjr_pkg::metric_t apriori_i;
	bcjr_pkg::metric_t gamma1_i;
	bcjr_pkg::metric_t gamma2_i;
	bcjr_pkg::alpha_vec_t alpha_i;
	logic out_valid_o;
	bcjr_pkg::idx_t idx_o;
	bcjr_pkg::metric_t llr_o;
	bcjr_pkg::metric_t ext_o;
	logic busy_o;

	// Blocks from the cases file
	string t_name [$];
	int t_len [$];
	int t_sym [$];
	int t_exp [$];
	// Symbol word holds sys, apriori, gamma1, gamma2, alpha0..7, low field first
	logic [191:0] s_word [$];
	// Expected word is idx, llr, ext
	logic [47:0] e_word [$];

	int errors;
	int checks;
	integer seed;

	tb_clk_gen i_clk_gen (.clk_o(clk));

	beta_llr_top i_beta_llr_top (
		.clk(clk),
		.rst(rst),
		.blk_valid_i(blk_valid_i),
		.blklen_i(blklen_i),
		.sym_valid_i(sym_valid_i),
		.sys_i(sys_i),
		.apriori_i(apriori_i),
		.gamma1_i(gamma1_i),
		.gamma2_i(gamma2_i),
		.alpha_i(alpha_i),
		.out_valid_o(out_valid_o),
		.idx_o(idx_o),
		.llr_o(llr_o),
		.ext_o(ext_o),
		.busy_o(busy_o)
	);

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	// Inputs change and outputs are sampled 1 unit after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cases file
	////////////////////////////////////////////////////////////////////////////

	task automatic read_cases();
		int fd;
		int n;
		int len;
		string line;
		string nm;
		logic [15:0] v [12];
		logic [191:0] w;
		fd = $fopen("tb/beta_llr_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Error: the cases file could not be opened");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) == "B") begin
				n = $sscanf(line, "B %s %h", nm, len);
				t_name.push_back(nm);
				t_len.push_back(len);
				t_sym.push_back(s_word.size());
				t_exp.push_back(e_word.size());
			end else if (n > 0 && line.getc(0) == "S") begin
				n = $sscanf(line, "S %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
					v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
				for (int i = 0; i < 12; i++)
					w[16*i +: 16] = v[i];
				s_word.push_back(w);
			end else if (n > 0 && line.getc(0) == "E") begin
				n = $sscanf(line, "E %h %h %h", v[0], v[1], v[2]);
				e_word.push_back({v[0], v[1], v[2]});
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One block: load, stray start request, then outputs
	////////////////////////////////////////////////////////////////////////////

	task automatic run_block(input int t);
		int err0;
		int cnt;
		int gap;
		logic [191:0] w;
		logic [47:0] e;
		err0 = errors;
		for (cnt = 0; busy_o && cnt < 100; cnt++)
			next_cycle();
		if (busy_o) begin
			errors++;
			$display("Error: DUT still busy before test %s", t_name[t]);
			return;
		end
		blk_valid_i = 1'b1;
		blklen_i = bcjr_pkg::idx_t'(t_len[t]);
		next_cycle();
		blk_valid_i = 1'b0;
		for (int i = 0; i < t_len[t]; i++) begin
			gap = $random(seed) & 3;
			for (int g = 0; g < gap; g++)
				next_cycle();
			w = s_word[t_sym[t] + i];
			sys_i = w[15:0];
			apriori_i = w[31:16];
			gamma1_i = w[47:32];
			gamma2_i = w[63:48];
			for (int s = 0; s < 8; s++)
				alpha_i[s] = w[64 + 16*s +: 16];
			sym_valid_i = 1'b1;
			next_cycle();
			sym_valid_i = 1'b0;
		end
		// Start request while busy must be ignored
		blk_valid_i = 1'b1;
		blklen_i = 13'd1;
		next_cycle();
		blk_valid_i = 1'b0;
		for (cnt = 0; !out_valid_o && cnt < 50; cnt++)
			next_cycle();
		if (!out_valid_o) begin
			errors++;
			$display("Error: no output appeared in test %s", t_name[t]);
			return;
		end
		for (int j = 0; j < t_len[t]; j++) begin
			e = e_word[t_exp[t] + j];
			check_val("out_valid_o", {31'd0, out_valid_o}, 32'd1);
			check_val("busy_o", {31'd0, busy_o}, 32'd1);
			check_val("idx_o", {19'd0, idx_o}, {19'd0, e[44:32]});
			check_val("llr_o", {16'd0, llr_o}, {16'd0, e[31:16]});
			check_val("ext_o", {16'd0, ext_o}, {16'd0, e[15:0]});
			next_cycle();
		end
		check_val("out_valid_o", {31'd0, out_valid_o}, 32'd0);
		check_val("busy_o", {31'd0, busy_o}, 32'd0);
		$display("test %s: %0d errors", t_name[t], errors - err0);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		seed = 32'haf9f_4c1e;
		rst = 1'b1;
		blk_valid_i = 1'b0;
		blklen_i = '0;
		sym_valid_i = 1'b0;
		sys_i = '0;
		apriori_i = '0;
		gamma1_i = '0;
		gamma2_i = '0;
		alpha_i = '0;
		read_cases();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Symbols without a started block
		sym_valid_i = 1'b1;
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			check_val("busy_o", {31'd0, busy_o}, 32'd0);
			check_val("out_valid_o", {31'd0, out_valid_o}, 32'd0);
		end
		sym_valid_i = 1'b0;
		$display("test idle_sym: %0d errors", errors);

		if (t_name.size() == 0 && errors == 0) begin
			errors++;
			$display("Error: the cases file holds no blocks");
		end
		for (int t = 0; t < t_name.size(); t++)
			run_block(t);

		$display("tests %0d, checks %0d, errors %0d", t_name.size() + 1, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/beta_llr_cases.txt */
# B name blklen | S sys apriori gamma1 gamma2 alpha0..alpha7 | E idx llr ext
# Values in hex, 16-bit two's complement, expected outputs in descending idx order
B zero1 1
S 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 0000 0000 0000
B rand8 8
S 0000 0003 fffe 0000 0000 0005 0000 0000 0000 0000 0000 0000
S 0004 0000 0007 0002 0000 0000 0000 0000 0000 0000 0000 0000
S ffff ffff 0000 fffb 0000 0000 0000 0000 0000 0000 0000 0000
S 0005 0002 0002 0003 0000 0000 0000 0000 0000 0000 fffc 0000
S 0000 0000 fffa ffff 0000 0000 0000 0000 0000 0000 0000 0000
S 000a fffc 0001 0001 0002 0000 0000 0000 0000 0000 0000 0000
S fffe 0000 fffd 0004 0000 0000 0000 0000 0000 0000 0000 0000
S 0003 0001 0005 fffe 0000 0000 0004 0000 0000 0000 0000 0000
E 0007 fff6 fff5
E 0006 0006 0006
E 0005 fffe fffa
E 0004 0009 0007
E 0003 fffa fff6
E 0002 000a 0009
E 0001 fff2 fff2
E 0000 0004 0001
B round6 6
S fff9 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
S 0007 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
S fffd fffd 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
S 0003 0003 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
S fff8 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
S 0008 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
E 0005 0000 fffa
E 0004 0000 0006
E 0003 0000 fffb
E 0002 0000 0005
E 0001 0000 fffb
E 0000 0000 0005
B reinit1 1
S 0003 0001 0005 fffe 0000 0000 0004 0000 0000 0000 0000 0000
E 0000 fff6 fff5

/* sim.f */
+incdir+hw
hw/bcjr_pkg.sv
hw/bcjr_if.sv
hw/sym_store.sv
hw/beta_recursion.sv
hw/llr_max_tree.sv
hw/extrinsic_scale.sv
hw/beta_llr_top.sv
tb/tb_clk_gen.sv
tb/beta_llr_sva.sv
tb/beta_llr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module beta_llr_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out="$(./obj_dir/Vbeta_llr_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
	exit 0
fi
exit 1
